//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // Widths that carry a meaning through the decoder
  typedef logic [31:0] word_t;
  typedef logic [95:0] instr_bytes_t;
  typedef logic [87:0] body_t;
  typedef logic [3:0]  len_t;

  // Internal opcode handed to the execute stage
  typedef enum logic [6:0] {
    opc_invalid = 7'd0,
    opc_nop,
    opc_add,
    opc_or,
    opc_and,
    opc_sub,
    opc_xor,
    opc_cmp,
    opc_mov,
    opc_inc,
    opc_dec,
    opc_jmp,
    opc_jcc
  } opc_t;

  typedef enum logic [1:0] {
    dest_none  = 2'd0,
    dest_reg   = 2'd1,
    dest_mem   = 2'd2,
    dest_flags = 2'd3
  } dest_kind_t;

  // Where operand 0 and operand 1 come from
  typedef enum logic [3:0] {
    form_none    = 4'd0,
    form_rm_reg,
    form_reg_rm,
    form_rm_imm,
    form_reg_imm,
    form_opreg,
    form_rel
  } opnd_form_t;

endpackage

`default_nettype wire

//--- src/decode_prefix.sv
`default_nettype none

module decode_prefix (
  input  decode_pkg::instr_bytes_t raw_instr,
  output decode_pkg::body_t        unprefixed_instr,
  output logic                     prefix_operand_16bit,
  output logic                     prefix_address_16bit,
  output logic [1:0]               prefix_rep,
  output logic [1:0]               prefix_count
);

  logic [7:0] byte0;
  logic [7:0] byte1;
  logic       take0;
  logic       take1;

  function automatic logic is_prefix(input logic [7:0] b);
    return (b == 8'h66) || (b == 8'h67) || (b == 8'hf2) || (b == 8'hf3);
  endfunction

  // F3 is rep, F2 is repne
  function automatic logic [1:0] rep_code(input logic [7:0] b);
    return (b == 8'hf3) ? 2'd1 : ((b == 8'hf2) ? 2'd2 : 2'd0);
  endfunction

  assign byte0 = raw_instr[7:0];
  assign byte1 = raw_instr[15:8];

  // Scanning stops at the first byte that is not a prefix
  assign take0 = is_prefix(byte0);
  assign take1 = take0 && is_prefix(byte1);

  assign prefix_count = {1'b0, take0} + {1'b0, take1};

  assign prefix_operand_16bit = (take0 && byte0 == 8'h66) || (take1 && byte1 == 8'h66);
  assign prefix_address_16bit = (take0 && byte0 == 8'h67) || (take1 && byte1 == 8'h67);

  // The later of two rep prefixes wins
  assign prefix_rep = (take1 && rep_code(byte1) != 2'd0) ? rep_code(byte1) :
                      (take0 ? rep_code(byte0) : 2'd0);

  always_comb begin
    case (prefix_count)
      2'd0:    unprefixed_instr = raw_instr[87:0];
      2'd1:    unprefixed_instr = raw_instr[95:8];
      default: unprefixed_instr = {8'h00, raw_instr[95:16]};
    endcase
  end

endmodule

`default_nettype wire

//--- src/decode_opcode.sv
`default_nettype none

module decode_opcode (
  input  decode_pkg::body_t      unprefixed_instr,
  output logic                   is_2byte,
  output decode_pkg::body_t      unescaped_instr,
  output decode_pkg::opc_t       opc,
  output decode_pkg::opnd_form_t opnd_form,
  output logic [1:0]             opnd_count,
  output logic                   imm_1byte,
  output logic                   reg_1byte,
  output logic                   opnd0_is_read,
  output logic                   opnd0_is_write,
  output logic                   opnd1_is_one,
  output logic                   opnd1_is_read,
  output logic                   opnd1_is_write,
  output logic                   opnd2_is_read,
  output logic                   opnd2_is_write,
  output logic                   source_is_sext,
  output logic                   disp_is_rel
);

  logic [7:0] op;
  logic [2:0] modrm_reg;

  // ALU index as found in bits 5:3 of the classic opcodes and in the reg field of 81/83
  function automatic decode_pkg::opc_t alu_opc(input logic [2:0] idx);
    case (idx)
      3'd0:    return decode_pkg::opc_add;
      3'd1:    return decode_pkg::opc_or;
      3'd4:    return decode_pkg::opc_and;
      3'd5:    return decode_pkg::opc_sub;
      3'd6:    return decode_pkg::opc_xor;
      3'd7:    return decode_pkg::opc_cmp;
      default: return decode_pkg::opc_invalid;
    endcase
  endfunction

  assign is_2byte        = unprefixed_instr[7:0] == 8'h0f;
  assign unescaped_instr = is_2byte ? {8'h00, unprefixed_instr[87:8]} : unprefixed_instr;
  assign op              = unescaped_instr[7:0];
  assign modrm_reg       = unescaped_instr[13:11];

  always_comb begin
    opc            = decode_pkg::opc_invalid;
    opnd_form      = decode_pkg::form_none;
    opnd_count     = 2'd0;
    imm_1byte      = 1'b0;
    reg_1byte      = 1'b0;
    opnd0_is_read  = 1'b0;
    opnd0_is_write = 1'b0;
    opnd1_is_one   = 1'b0;
    opnd1_is_read  = 1'b0;
    opnd1_is_write = 1'b0;
    opnd2_is_read  = 1'b0;
    opnd2_is_write = 1'b0;
    source_is_sext = 1'b0;
    disp_is_rel    = 1'b0;
    if (is_2byte) begin
      // Jcc with a full-size displacement, condition in the low nibble
      if (op[7:4] == 4'h8) begin
        opc           = decode_pkg::opc_jcc;
        opnd_form     = decode_pkg::form_rel;
        opnd_count    = 2'd1;
        opnd0_is_read = 1'b1;
        opnd2_is_read = 1'b1;
        disp_is_rel   = 1'b1;
      end
    end else begin
      casez (op)
        8'b00???001, 8'b00???011: begin
          opc            = alu_opc(op[5:3]);
          opnd_form      = op[1] ? decode_pkg::form_reg_rm : decode_pkg::form_rm_reg;
          opnd_count     = 2'd2;
          opnd0_is_read  = 1'b1;
          opnd0_is_write = op[5:3] != 3'd7;
          opnd1_is_read  = 1'b1;
          opnd2_is_write = 1'b1;
        end
        8'h81, 8'h83: begin
          opc            = alu_opc(modrm_reg);
          opnd_form      = decode_pkg::form_rm_imm;
          opnd_count     = 2'd2;
          opnd0_is_read  = 1'b1;
          opnd0_is_write = modrm_reg != 3'd7;
          opnd1_is_read  = 1'b1;
          opnd2_is_write = 1'b1;
          imm_1byte      = op[1];
          source_is_sext = op[1];
        end
        8'h89, 8'h8b: begin
          opc            = decode_pkg::opc_mov;
          opnd_form      = op[1] ? decode_pkg::form_reg_rm : decode_pkg::form_rm_reg;
          opnd_count     = 2'd2;
          opnd0_is_write = 1'b1;
          opnd1_is_read  = 1'b1;
        end
        8'b1011_1???: begin
          opc            = decode_pkg::opc_mov;
          opnd_form      = decode_pkg::form_reg_imm;
          opnd_count     = 2'd2;
          opnd0_is_write = 1'b1;
          opnd1_is_read  = 1'b1;
        end
        8'b0100_????: begin
          opc            = op[3] ? decode_pkg::opc_dec : decode_pkg::opc_inc;
          opnd_form      = decode_pkg::form_opreg;
          opnd_count     = 2'd2;
          opnd0_is_read  = 1'b1;
          opnd0_is_write = 1'b1;
          opnd1_is_one   = 1'b1;
          opnd2_is_write = 1'b1;
        end
        8'h90: opc = decode_pkg::opc_nop;
        8'heb: begin
          opc           = decode_pkg::opc_jmp;
          opnd_form     = decode_pkg::form_rel;
          opnd_count    = 2'd1;
          opnd0_is_read = 1'b1;
          imm_1byte     = 1'b1;
          disp_is_rel   = 1'b1;
        end
        default: opc = decode_pkg::opc_invalid;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/decode_opnds.sv
`default_nettype none

module decode_opnds #(
  parameter bit addr16_mask_en = 1'b1
) (
  input  decode_pkg::body_t      unescaped_instr,
  input  decode_pkg::word_t      eax, ebx, ecx, edx,
  input  decode_pkg::word_t      esi, edi, esp, ebp,
  input  logic                   hint1_is_write,
  input  decode_pkg::word_t      hint1_address,
  input  decode_pkg::word_t      hint1_data,
  input  logic                   hint2_is_write,
  input  decode_pkg::word_t      hint2_address,
  input  decode_pkg::word_t      hint2_data,
  input  decode_pkg::opc_t       opc,
  input  decode_pkg::opnd_form_t opnd_form,
  input  logic [1:0]             opnd_count,
  input  logic                   imm_1byte,
  input  logic                   reg_1byte,
  input  logic                   prefix_operand_16bit,
  input  logic                   prefix_address_16bit,
  input  logic                   opnd0_is_read,
  input  logic                   opnd0_is_write,
  input  logic                   opnd1_is_one,
  input  logic                   opnd1_is_read,
  input  logic                   opnd1_is_write,
  input  logic                   opnd2_is_read,
  input  logic                   opnd2_is_write,
  input  logic                   source_is_sext,
  input  logic                   disp_is_rel,
  output decode_pkg::len_t       instr_body_len,
  output decode_pkg::word_t      opnd0_r,
  output decode_pkg::word_t      opnd1_r,
  output decode_pkg::word_t      opnd2_r,
  output decode_pkg::dest_kind_t dest0_kind,
  output decode_pkg::dest_kind_t dest1_kind,
  output decode_pkg::word_t      dest0_sel,
  output decode_pkg::word_t      dest1_sel
);

  logic [7:0]        op;
  logic [7:0]        modrm;
  logic [7:0]        sib;
  logic              has_modrm, has_sib, has_imm, has_index;
  logic              rm_is_mem, no_base, sext;
  logic [2:0]        disp_len, imm_len;
  logic [3:0]        disp_off, imm_off;
  decode_pkg::body_t disp_win, imm_win;
  decode_pkg::word_t regs [8];
  decode_pkg::word_t disp, imm, base_val, index_val, ea_full, ea;
  decode_pkg::word_t mem_val, rm_val, mask, val0, val1;
  logic              mem0, mem1;
  logic [2:0]        num0, num1;

  assign op    = unescaped_instr[7:0];
  assign modrm = unescaped_instr[15:8];
  assign sib   = unescaped_instr[23:16];

  // Register file in x86 numbering
  assign regs[0] = eax;
  assign regs[1] = ecx;
  assign regs[2] = edx;
  assign regs[3] = ebx;
  assign regs[4] = esp;
  assign regs[5] = ebp;
  assign regs[6] = esi;
  assign regs[7] = edi;

  assign has_modrm = opnd_form inside {decode_pkg::form_rm_reg, decode_pkg::form_reg_rm,
                                       decode_pkg::form_rm_imm};
  assign has_imm   = opnd_form inside {decode_pkg::form_rm_imm, decode_pkg::form_reg_imm,
                                       decode_pkg::form_rel};
  assign rm_is_mem = has_modrm && (modrm[7:6] != 2'd3);
  assign has_sib   = rm_is_mem && (modrm[2:0] == 3'd4);
  assign has_index = has_sib && (sib[5:3] != 3'd4);
  // Under mod 00, base 101 means a bare disp32
  assign no_base   = (modrm[7:6] == 2'd0) && (has_sib ? sib[2:0] == 3'd5 : modrm[2:0] == 3'd5);

  always_comb begin
    if (!rm_is_mem) disp_len = 3'd0;
    else if (modrm[7:6] == 2'd1) disp_len = 3'd1;
    else if (modrm[7:6] == 2'd2 || no_base) disp_len = 3'd4;
    else disp_len = 3'd0;
  end

  assign imm_len = !has_imm ? 3'd0 : (imm_1byte ? 3'd1 : (prefix_operand_16bit ? 3'd2 : 3'd4));

  // Byte 0 is the opcode, then ModR/M, SIB, displacement and immediate
  assign disp_off = 4'd1 + {3'd0, has_modrm} + {3'd0, has_sib};
  assign imm_off  = disp_off + {1'b0, disp_len};
  assign disp_win = unescaped_instr >> {disp_off, 3'b000};
  assign imm_win  = unescaped_instr >> {imm_off, 3'b000};

  assign disp = (disp_len == 3'd1) ? {{24{disp_win[7]}}, disp_win[7:0]} :
                ((disp_len == 3'd4) ? disp_win[31:0] : '0);

  // Relative targets are always signed
  assign sext = source_is_sext || disp_is_rel;

  always_comb begin
    case (imm_len)
      3'd1:    imm = sext ? {{24{imm_win[7]}}, imm_win[7:0]} : {24'd0, imm_win[7:0]};
      3'd2:    imm = sext ? {{16{imm_win[15]}}, imm_win[15:0]} : {16'd0, imm_win[15:0]};
      3'd4:    imm = imm_win[31:0];
      default: imm = '0;
    endcase
  end

  assign base_val  = no_base ? '0 : regs[has_sib ? sib[2:0] : modrm[2:0]];
  assign index_val = has_index ? (regs[sib[5:3]] << sib[7:6]) : '0;
  assign ea_full   = base_val + index_val + disp;
  assign ea = (addr16_mask_en && prefix_address_16bit) ? {16'd0, ea_full[15:0]} : ea_full;

  // Memory reads come from a matching read hint, hint1 first
  assign mem_val = (!hint1_is_write && hint1_address == ea) ? hint1_data :
                   ((!hint2_is_write && hint2_address == ea) ? hint2_data : '0);
  assign rm_val  = rm_is_mem ? mem_val : regs[modrm[2:0]];

  assign mask = reg_1byte ? 32'h0000_00ff :
                (prefix_operand_16bit ? 32'h0000_ffff : 32'hffff_ffff);

  always_comb begin
    val0 = '0;
    val1 = '0;
    mem0 = 1'b0;
    mem1 = 1'b0;
    num0 = 3'd0;
    num1 = 3'd0;
    case (opnd_form)
      decode_pkg::form_rm_reg: begin
        val0 = rm_val;
        val1 = regs[modrm[5:3]];
        mem0 = rm_is_mem;
        num0 = modrm[2:0];
        num1 = modrm[5:3];
      end
      decode_pkg::form_reg_rm: begin
        val0 = regs[modrm[5:3]];
        val1 = rm_val;
        num0 = modrm[5:3];
        mem1 = rm_is_mem;
        num1 = modrm[2:0];
      end
      decode_pkg::form_rm_imm: begin
        val0 = rm_val;
        val1 = imm;
        mem0 = rm_is_mem;
        num0 = modrm[2:0];
      end
      decode_pkg::form_reg_imm, decode_pkg::form_opreg: begin
        val0 = regs[op[2:0]];
        val1 = imm;
        num0 = op[2:0];
      end
      decode_pkg::form_rel: val0 = imm;
      default: val0 = '0;
    endcase
  end

  assign opnd0_r = (opnd_count != 2'd0 && opnd0_is_read) ?
                   (disp_is_rel ? val0 : val0 & mask) : '0;
  assign opnd1_r = (opnd_count < 2'd2) ? '0 :
                   (opnd1_is_one ? 32'd1 : (opnd1_is_read ? val1 & mask : '0));
  assign opnd2_r = (opnd2_is_read && opc == decode_pkg::opc_jcc) ? {28'd0, op[3:0]} : '0;

  always_comb begin
    dest0_kind = decode_pkg::dest_none;
    dest0_sel  = '0;
    if (opnd0_is_write) begin
      dest0_kind = mem0 ? decode_pkg::dest_mem : decode_pkg::dest_reg;
      dest0_sel  = mem0 ? ea : {29'd0, num0};
    end else if (opnd1_is_write) begin
      dest0_kind = mem1 ? decode_pkg::dest_mem : decode_pkg::dest_reg;
      dest0_sel  = mem1 ? ea : {29'd0, num1};
    end
  end

  // The flags result is the second destination
  assign dest1_kind = opnd2_is_write ? decode_pkg::dest_flags : decode_pkg::dest_none;
  assign dest1_sel  = '0;

  assign instr_body_len = {3'd0, has_modrm} + {3'd0, has_sib} + {1'b0, disp_len} +
                          {1'b0, imm_len};

endmodule

`default_nettype wire

//--- src/decode.sv
`default_nettype none

module decode #(
  parameter bit addr16_mask_en = 1'b1
) (
  input  decode_pkg::instr_bytes_t raw_instr,
  input  decode_pkg::word_t        eax, ebx, ecx, edx,
  input  decode_pkg::word_t        esi, edi, esp, ebp,
  input  logic                     hint1_is_write,
  input  decode_pkg::word_t        hint1_address,
  input  decode_pkg::word_t        hint1_data,
  input  logic                     hint2_is_write,
  input  decode_pkg::word_t        hint2_address,
  input  decode_pkg::word_t        hint2_data,
  output decode_pkg::len_t         instr_len,
  output decode_pkg::opc_t         opc,
  output decode_pkg::word_t        opnd0_r,
  output decode_pkg::word_t        opnd1_r,
  output decode_pkg::word_t        opnd2_r,
  output decode_pkg::dest_kind_t   dest0_kind,
  output decode_pkg::dest_kind_t   dest1_kind,
  output decode_pkg::word_t        dest0_sel,
  output decode_pkg::word_t        dest1_sel
);

  decode_pkg::body_t      unprefixed_instr, unescaped_instr;
  logic                   prefix_operand_16bit, prefix_address_16bit;
  logic [1:0]             prefix_rep, prefix_count;
  logic                   is_2byte;
  decode_pkg::opc_t       opc_table;
  decode_pkg::opnd_form_t opnd_form;
  logic [1:0]             opnd_count;
  logic                   imm_1byte, reg_1byte;
  logic                   opnd0_is_read, opnd0_is_write;
  logic                   opnd1_is_one, opnd1_is_read, opnd1_is_write;
  logic                   opnd2_is_read, opnd2_is_write;
  logic                   source_is_sext, disp_is_rel;
  decode_pkg::len_t       instr_body_len;

  decode_prefix decode_prefix_x (.*);

  decode_opcode decode_opcode_x (
    .opc(opc_table),
    .*
  );

  // F2 or F3 in front of 0F selects vector encodings the core does not have
  assign opc = (is_2byte && prefix_rep != 2'd0) ? decode_pkg::opc_invalid : opc_table;

  decode_opnds #(
    .addr16_mask_en(addr16_mask_en)
  ) decode_opnds_x (.*);

  // Prefixes, one or two opcode bytes, then ModR/M, SIB, displacement and immediate
  assign instr_len = {2'd0, prefix_count} + (is_2byte ? 4'd2 : 4'd1) + instr_body_len;

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none

module decode_stage #(
  parameter bit addr16_mask_en = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instr_valid,
  input  decode_pkg::instr_bytes_t raw_instr,
  input  decode_pkg::word_t        eax, ebx, ecx, edx,
  input  decode_pkg::word_t        esi, edi, esp, ebp,
  input  logic                     hint1_is_write,
  input  decode_pkg::word_t        hint1_address,
  input  decode_pkg::word_t        hint1_data,
  input  logic                     hint2_is_write,
  input  decode_pkg::word_t        hint2_address,
  input  decode_pkg::word_t        hint2_data,
  output decode_pkg::len_t         instr_len,
  output decode_pkg::opc_t         opc,
  output decode_pkg::word_t        opnd0_r,
  output decode_pkg::word_t        opnd1_r,
  output decode_pkg::word_t        opnd2_r,
  output decode_pkg::dest_kind_t   dest0_kind,
  output decode_pkg::dest_kind_t   dest1_kind,
  output decode_pkg::word_t        dest0_sel,
  output decode_pkg::word_t        dest1_sel,
  output logic                     out_valid
);

  // Input rank
  logic                     valid_q;
  decode_pkg::instr_bytes_t raw_q;
  decode_pkg::word_t        eax_q, ebx_q, ecx_q, edx_q, esi_q, edi_q, esp_q, ebp_q;
  logic                     h1_wr_q, h2_wr_q;
  decode_pkg::word_t        h1_addr_q, h1_data_q, h2_addr_q, h2_data_q;

  // Combinational decode results
  decode_pkg::len_t       len_d;
  decode_pkg::opc_t       opc_d;
  decode_pkg::word_t      opnd0_d, opnd1_d, opnd2_d, sel0_d, sel1_d;
  decode_pkg::dest_kind_t kind0_d, kind1_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_q   <= instr_valid;
      out_valid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      raw_q     <= raw_instr;
      eax_q     <= eax;
      ebx_q     <= ebx;
      ecx_q     <= ecx;
      edx_q     <= edx;
      esi_q     <= esi;
      edi_q     <= edi;
      esp_q     <= esp;
      ebp_q     <= ebp;
      h1_wr_q   <= hint1_is_write;
      h1_addr_q <= hint1_address;
      h1_data_q <= hint1_data;
      h2_wr_q   <= hint2_is_write;
      h2_addr_q <= hint2_address;
      h2_data_q <= hint2_data;
    end
    // Outputs hold until the next valid instruction leaves the input rank
    if (valid_q) begin
      instr_len  <= len_d;
      opc        <= opc_d;
      opnd0_r    <= opnd0_d;
      opnd1_r    <= opnd1_d;
      opnd2_r    <= opnd2_d;
      dest0_kind <= kind0_d;
      dest1_kind <= kind1_d;
      dest0_sel  <= sel0_d;
      dest1_sel  <= sel1_d;
    end
  end

  decode #(
    .addr16_mask_en(addr16_mask_en)
  ) decode_x (
    .raw_instr(raw_q),
    .eax(eax_q),
    .ebx(ebx_q),
    .ecx(ecx_q),
    .edx(edx_q),
    .esi(esi_q),
    .edi(edi_q),
    .esp(esp_q),
    .ebp(ebp_q),
    .hint1_is_write(h1_wr_q),
    .hint1_address(h1_addr_q),
    .hint1_data(h1_data_q),
    .hint2_is_write(h2_wr_q),
    .hint2_address(h2_addr_q),
    .hint2_data(h2_data_q),
    .instr_len(len_d),
    .opc(opc_d),
    .opnd0_r(opnd0_d),
    .opnd1_r(opnd1_d),
    .opnd2_r(opnd2_d),
    .dest0_kind(kind0_d),
    .dest1_kind(kind1_d),
    .dest0_sel(sel0_d),
    .dest1_sel(sel1_d)
  );

endmodule

`default_nettype wire

//--- tb/decode_stage_assertions.sv
`default_nettype none

module decode_stage_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   instr_valid,
  input logic                   out_valid,
  input decode_pkg::dest_kind_t dest0_kind,
  input decode_pkg::dest_kind_t dest1_kind
);

  int fail_count = 0;

  // A reset cycle leaves nothing in the output rank
  reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high in the cycle after reset");
    end

  // Two register ranks between instr_valid and out_valid
  valid_latency: assert property (@(posedge clk)
      (!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(instr_valid, 2)))
    else begin
      fail_count++;
      $error("out_valid does not follow instr_valid by two edges");
    end

  kinds_known: assert property (@(posedge clk)
      out_valid |-> !$isunknown(dest0_kind) && !$isunknown(dest1_kind))
    else begin
      fail_count++;
      $error("destination kind unknown while out_valid is high");
    end

endmodule

bind decode_stage decode_stage_assertions assertions_x (
  .clk(clk),
  .rst(rst),
  .instr_valid(instr_valid),
  .out_valid(out_valid),
  .dest0_kind(dest0_kind),
  .dest1_kind(dest1_kind)
);

`default_nettype wire

//--- tb/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb;

  localparam int num_patterns = 24;
  localparam int entry_bits   = 668;
  // At most three input cycles per test, plus reset and pipeline latency
  localparam int max_cycles   = num_patterns * 4 + 20;

  logic                     clk;
  logic                     rst;
  logic                     instr_valid;
  decode_pkg::instr_bytes_t raw_instr;
  decode_pkg::word_t        eax, ebx, ecx, edx, esi, edi, esp, ebp;
  logic                     hint1_is_write, hint2_is_write;
  decode_pkg::word_t        hint1_address, hint1_data, hint2_address, hint2_data;
  decode_pkg::len_t         instr_len;
  decode_pkg::opc_t         opc;
  decode_pkg::word_t        opnd0_r, opnd1_r, opnd2_r, dest0_sel, dest1_sel;
  decode_pkg::dest_kind_t   dest0_kind, dest1_kind;
  logic                     out_valid;

  logic [entry_bits-1:0] patterns [num_patterns];
  logic [entry_bits-1:0] expected_q [$];
  int                    seed;
  int                    errors;
  int                    test_errors;
  int                    failed_tests;
  int                    done_count;
  int                    cycles;

  decode_stage #(.addr16_mask_en(1'b1)) uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // The pattern file lists instruction bytes in reading order, first byte leftmost
  function automatic decode_pkg::instr_bytes_t bytes_in_order(input logic [95:0] listed);
    decode_pkg::instr_bytes_t r;
    for (int i = 0; i < 12; i++) begin
      r[8*i +: 8] = listed[95-8*i -: 8];
    end
    return r;
  endfunction

  task automatic check_len(input string name, input decode_pkg::len_t got,
                           input decode_pkg::len_t exp);
    if (got !== exp) begin
      $display("Fail %s in test %0d: got %h, expected %h", name, done_count, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_opc(input string name, input decode_pkg::opc_t got,
                           input decode_pkg::opc_t exp);
    if (got !== exp) begin
      $display("Fail %s in test %0d: got %h, expected %h", name, done_count, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_word(input string name, input decode_pkg::word_t got,
                            input decode_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail %s in test %0d: got %h, expected %h", name, done_count, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_kind(input string name, input decode_pkg::dest_kind_t got,
                            input decode_pkg::dest_kind_t exp);
    if (got !== exp) begin
      $display("Fail %s in test %0d: got %h, expected %h", name, done_count, got, exp);
      test_errors++;
    end
  endtask

  task automatic drive_entry(input logic [entry_bits-1:0] entry);
    raw_instr      <= bytes_in_order(entry[667:572]);
    {eax, ebx, ecx, edx, esi, edi, esp, ebp} <= entry[571:316];
    hint1_is_write <= entry[312];
    hint1_address  <= entry[311:280];
    hint1_data     <= entry[279:248];
    hint2_is_write <= entry[244];
    hint2_address  <= entry[243:212];
    hint2_data     <= entry[211:180];
    instr_valid    <= 1'b1;
  endtask

  task automatic compare_result(input logic [entry_bits-1:0] entry);
    test_errors = 0;
    check_len("instr_len", instr_len, entry[179:176]);
    check_opc("opc", opc, decode_pkg::opc_t'(entry[174:168]));
    check_word("opnd0_r", opnd0_r, entry[167:136]);
    check_word("opnd1_r", opnd1_r, entry[135:104]);
    check_word("opnd2_r", opnd2_r, entry[103:72]);
    check_kind("dest0_kind", dest0_kind, decode_pkg::dest_kind_t'(entry[69:68]));
    check_kind("dest1_kind", dest1_kind, decode_pkg::dest_kind_t'(entry[65:64]));
    check_word("dest0_sel", dest0_sel, entry[63:32]);
    check_word("dest1_sel", dest1_sel, entry[31:0]);
    if (test_errors == 0) begin
      $display("Test %0d passed", done_count);
    end else begin
      $display("Test %0d failed with %0d mismatches", done_count, test_errors);
      failed_tests++;
      errors += test_errors;
    end
    done_count++;
  endtask

  // Outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (expected_q.size() == 0) begin
        $display("A result arrived with no instruction outstanding");
        errors++;
      end else begin
        compare_result(expected_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: only %0d of %0d results arrived within %0d cycles",
               done_count, num_patterns, max_cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int gap;
    int total;
    int reset_errors;
    seed           = 32'h985e;
    errors         = 0;
    failed_tests   = 0;
    done_count     = 0;
    cycles         = 0;
    reset_errors   = 0;
    rst            = 1'b1;
    instr_valid    = 1'b0;
    raw_instr      = '0;
    {eax, ebx, ecx, edx, esi, edi, esp, ebp} = '0;
    hint1_is_write = 1'b0;
    hint1_address  = '0;
    hint1_data     = '0;
    hint2_is_write = 1'b0;
    hint2_address  = '0;
    hint2_data     = '0;
    $readmemh("tb/decode_patterns.hex", patterns);

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Zero to two idle cycles ahead of each instruction
    for (int i = 0; i < num_patterns; i++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        instr_valid <= 1'b0;
        @(posedge clk);
      end
      drive_entry(patterns[i]);
      expected_q.push_back(patterns[i]);
      @(posedge clk);
    end
    instr_valid <= 1'b0;

    wait (done_count == num_patterns);
    @(posedge clk);

    // A reset with one instruction in the input rank and another arriving drops both
    drive_entry(patterns[0]);
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    rst         <= 1'b0;
    instr_valid <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (out_valid) begin
        reset_errors++;
      end
    end
    if (reset_errors == 0) begin
      $display("Reset test passed");
    end else begin
      $display("Reset test failed: out_valid high after a reset with instructions in flight");
      errors += reset_errors;
    end
    repeat (3) @(posedge clk);

    total = errors + uut.assertions_x.fail_count;
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             num_patterns, num_patterns - failed_tests, failed_tests,
             uut.assertions_x.fail_count);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/decode_patterns.hex
// instr bytes (first byte leftmost) _ eax ebx ecx edx esi edi esp ebp _ h1 wr addr data _ h2 wr addr data
// then expected: len _ opc _ opnd0 _ opnd1 _ opnd2 _ dest0 kind _ dest1 kind _ dest0 sel _ dest1 sel
01d800000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_02_00001000_00002000_00000000_1_3_00000000_00000000
2bca00000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_05_00000003_00000040_00000000_1_3_00000001_00000000
6631f8000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_3_06_00001000_00006000_00000000_1_3_00000000_00000000
39c100000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_07_00000003_00001000_00000000_0_3_00000000_00000000
89e500000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_08_00000000_00007000_00000000_1_0_00000005_00000000
014310000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00002010_aaaa5555_0_00002010_bbbb0000_3_02_aaaa5555_00001000_00000000_2_3_00002010_00000000
038e00010000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_1_00000600_11111111_0_00000600_22223333_6_02_00000003_22223333_00000000_1_3_00000001_00000000
230534120000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00001238_12121212_0_00001230_34343434_6_04_00001000_00000000_00000000_1_3_00000000_00000000
89048b000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_3_08_00000000_00001000_00000000_2_0_0000200c_00000000
8b54b5f00000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_000093f0_0badf00d_0_00000000_00000000_4_08_00000000_0badf00d_00000000_1_0_00000002_00000000
8b044d001000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00001000_99999999_0_00001006_5a5a5a5a_7_08_00000000_5a5a5a5a_00000000_1_0_00000000_00000000
670187000001000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00006000_77778888_0_00000000_00000000_7_02_77778888_00001000_00000000_2_3_00006000_00000000
81c378563412000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_6_02_00002000_12345678_00000000_1_3_00000003_00000000
83e9f0000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_3_05_00000003_fffffff0_00000000_1_3_00000001_00000000
6681f7341200000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_5_06_00006000_00001234_00000000_1_3_00000007_00000000
6683f8ff0000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_4_07_00001000_0000ffff_00000000_0_3_00000000_00000000
bfefbeadde00000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_5_08_00000000_deadbeef_00000000_1_0_00000007_00000000
ebfe00000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_0b_fffffffe_00000000_00000000_0_0_00000000_00000000
0f8500010000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_6_0c_00000100_00000000_00000005_0_0_00000000_00000000
0f8cf0ffffff000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_6_0c_fffffff0_00000000_0000000c_0_0_00000000_00000000
460000000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_1_09_00000500_00000001_00000000_1_3_00000006_00000000
4f0000000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_1_0a_80006000_00000001_00000000_1_3_00000007_00000000
f40000000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_1_00_00000000_00000000_00000000_0_0_00000000_00000000
f39000000000000000000000_00001000_00002000_00000003_00000040_00000500_80006000_00007000_00008000_0_00000000_00000000_0_00000000_00000000_2_01_00000000_00000000_00000000_0_0_00000000_00000000

//--- all.f
src/decode_pkg.sv
src/decode_prefix.sv
src/decode_opcode.sv
src/decode_opnds.sv
src/decode.sv
src/decode_stage.sv
tb/decode_stage_assertions.sv
tb/decode_stage_tb.sv

//--- Makefile
VERILATOR       ?= verilator
TOP             ?= decode_stage_tb
FILE_LIST       ?= all.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --assert -j 0
PASS_TEXT       ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
